// ==== logic/uart_macros.svh ====
// uart sizes, frame lengths, reset values and register addresses shared by the core

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// data bits carried in one frame
`define UART_DATA_SIZE        8

// clocks-per-bit divider and its value out of reset
`define UART_BAUD_DIV_SIZE    16
`define UART_BAUD_DIV_RESET   16'd16

// bit counter width and the number of bit times in a whole frame
`define UART_FRAME_BIT_COUNT  4
`define UART_FRAME_1STOP      4'd10
`define UART_FRAME_2STOP      4'd11

// register port widths
`define UART_REG_SIZE         16
`define UART_ADDR_SIZE        2

// register map
`define UART_ADDR_DATA        2'd0
`define UART_ADDR_CTRL        2'd1
`define UART_ADDR_STATUS      2'd2
`define UART_ADDR_STOP        2'd3

`endif

// ==== logic/uart_pkg.sv ====
// uart shared types for the FSM states, register opcodes and the structs between blocks

`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

    // a request is live only in the cycle where op is not REG_NONE
    typedef enum logic [1:0] {
        REG_NONE  = 2'd0,
        REG_WRITE = 2'd1,
        REG_READ  = 2'd2
    } uart_reg_op_e;

    typedef struct packed {
        logic [`UART_BAUD_DIV_SIZE-1:0] baud_div;
        logic                           two_stop;
    } uart_cfg_t;

    typedef struct packed {
        uart_reg_op_e                   op;
        logic [`UART_ADDR_SIZE-1:0]     addr;
        logic [`UART_REG_SIZE-1:0]      wdata;
    } uart_bus_req_t;

    typedef struct packed {
        logic                           rvalid;
        logic [`UART_REG_SIZE-1:0]      rdata;
    } uart_bus_rsp_t;

    // valid is a one-cycle strobe, data and frame_err are only meaningful with it
    typedef struct packed {
        logic [`UART_DATA_SIZE-1:0]     data;
        logic                           frame_err;
        logic                           valid;
    } uart_rx_byte_t;

endpackage

`default_nettype wire

// ==== logic/uart_tx.sv ====
// uart transmitter that sends a start bit, eight data bits LSB first and one or two stop bits

`default_nettype none

`include "uart_macros.svh"

module uart_tx (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire uart_pkg::uart_cfg_t        cfg_i,
    input  wire logic                       start_i,
    input  wire logic [`UART_DATA_SIZE-1:0] data_i,
    output logic                            ready_o,
    output logic                            tx_o
);

    import uart_pkg::*;

    // start bit plus the data byte
    localparam int SHIFT_SIZE = `UART_DATA_SIZE + 1;

    uart_tx_state_e                         state_ff, state_next;
    logic [`UART_BAUD_DIV_SIZE-1:0]         sample_count_ff, sample_count_next;
    logic [`UART_FRAME_BIT_COUNT-1:0]       bit_count_ff, bit_count_next;
    logic [SHIFT_SIZE-1:0]                  shifter_ff, shifter_next;
    logic [`UART_FRAME_BIT_COUNT-1:0]       frame_size;
    logic                                   sample_pulse;
    logic                                   last_bit;
    logic                                   tx_bit;

    assign frame_size   = cfg_i.two_stop ? `UART_FRAME_2STOP : `UART_FRAME_1STOP;
    assign sample_pulse = (sample_count_ff <= `UART_BAUD_DIV_SIZE'(1));
    assign last_bit     = (bit_count_ff == `UART_FRAME_BIT_COUNT'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff        <= TX_IDLE;
            sample_count_ff <= '0;
            bit_count_ff    <= '0;
        end else begin
            state_ff        <= state_next;
            sample_count_ff <= sample_count_next;
            bit_count_ff    <= bit_count_next;
        end
    end

    always_ff @(posedge clk) begin
        shifter_ff <= shifter_next;
    end

    // the bit timer sits at baud_div outside of TX_DATA so the first bit gets a full period
    always_comb begin
        tx_bit            = 1'b1;
        state_next        = state_ff;
        sample_count_next = cfg_i.baud_div;
        bit_count_next    = bit_count_ff;
        shifter_next      = shifter_ff;

        case (state_ff)
            TX_IDLE: begin
                if (start_i) begin
                    state_next = TX_START;
                end
            end

            TX_START: begin
                shifter_next   = {data_i, 1'b0};
                bit_count_next = frame_size;
                state_next     = TX_DATA;
            end

            TX_DATA: begin
                tx_bit = shifter_ff[0];
                if (sample_pulse) begin
                    // ones come in from the top, so the stop bits need no extra state
                    bit_count_next = bit_count_ff - `UART_FRAME_BIT_COUNT'(1);
                    shifter_next   = {1'b1, shifter_ff[SHIFT_SIZE-1:1]};
                    if (last_bit) begin
                        state_next = TX_IDLE;
                    end
                end else begin
                    sample_count_next = sample_count_ff - `UART_BAUD_DIV_SIZE'(1);
                end
            end

            default: begin
                state_next = TX_IDLE;
            end
        endcase
    end

    // ready drops through TX_START and TX_DATA and comes back right after the last stop bit
    assign ready_o = (state_ff == TX_IDLE);
    assign tx_o    = tx_bit;

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
// uart receiver that synchronizes the line, finds the start bit and samples each bit mid-bit

`default_nettype none

`include "uart_macros.svh"

module uart_rx (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire uart_pkg::uart_cfg_t    cfg_i,
    input  wire logic                   rx_i,
    output uart_pkg::uart_rx_byte_t     byte_o
);

    import uart_pkg::*;

    logic                                   rx_meta_ff;
    logic                                   rx_sync_ff;
    logic                                   rx_prev_ff;
    uart_rx_state_e                         state_ff, state_next;
    logic [`UART_BAUD_DIV_SIZE-1:0]         sample_count_ff, sample_count_next;
    logic [`UART_FRAME_BIT_COUNT-1:0]       bit_count_ff, bit_count_next;
    logic [`UART_DATA_SIZE-1:0]             data_ff, data_next;
    logic                                   frame_err_ff, frame_err_next;
    logic                                   valid_ff, valid_next;
    logic                                   sample_pulse;
    logic                                   start_edge;

    // two flops against metastability, the third one finds the falling edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta_ff <= 1'b1;
            rx_sync_ff <= 1'b1;
            rx_prev_ff <= 1'b1;
        end else begin
            rx_meta_ff <= rx_i;
            rx_sync_ff <= rx_meta_ff;
            rx_prev_ff <= rx_sync_ff;
        end
    end

    assign start_edge   = rx_prev_ff && !rx_sync_ff;
    assign sample_pulse = (sample_count_ff <= `UART_BAUD_DIV_SIZE'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff        <= RX_IDLE;
            sample_count_ff <= '0;
            bit_count_ff    <= '0;
            valid_ff        <= 1'b0;
        end else begin
            state_ff        <= state_next;
            sample_count_ff <= sample_count_next;
            bit_count_ff    <= bit_count_next;
            valid_ff        <= valid_next;
        end
    end

    always_ff @(posedge clk) begin
        data_ff      <= data_next;
        frame_err_ff <= frame_err_next;
    end

    always_comb begin
        state_next     = state_ff;
        bit_count_next = bit_count_ff;
        data_next      = data_ff;
        frame_err_next = frame_err_ff;
        valid_next     = 1'b0;
        if (sample_pulse) begin
            sample_count_next = cfg_i.baud_div;
        end else begin
            sample_count_next = sample_count_ff - `UART_BAUD_DIV_SIZE'(1);
        end

        case (state_ff)
            RX_IDLE: begin
                // half a bit to reach the middle of the start bit
                sample_count_next = cfg_i.baud_div >> 1;
                bit_count_next    = '0;
                if (start_edge) begin
                    state_next = RX_START;
                end
            end

            RX_START: begin
                if (sample_pulse) begin
                    // a glitch that is high again at mid-bit is not a start bit
                    state_next = rx_sync_ff ? RX_IDLE : RX_DATA;
                end
            end

            RX_DATA: begin
                if (sample_pulse) begin
                    data_next      = {rx_sync_ff, data_ff[`UART_DATA_SIZE-1:1]};
                    bit_count_next = bit_count_ff + `UART_FRAME_BIT_COUNT'(1);
                    if (bit_count_ff == `UART_FRAME_BIT_COUNT'(`UART_DATA_SIZE - 1)) begin
                        state_next = RX_STOP;
                    end
                end
            end

            RX_STOP: begin
                // only the first stop bit is checked, a second one just lengthens the gap
                if (sample_pulse) begin
                    valid_next     = 1'b1;
                    frame_err_next = !rx_sync_ff;
                    state_next     = RX_IDLE;
                end
            end

            default: begin
                state_next = RX_IDLE;
            end
        endcase
    end

    assign byte_o = '{data: data_ff, frame_err: frame_err_ff, valid: valid_ff};

endmodule

`default_nettype wire

// ==== logic/uart_regs.sv ====
// uart register block that decodes strobes, holds the line setup and receive buffer, answers reads

`default_nettype none

`include "uart_macros.svh"

module uart_regs (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire uart_pkg::uart_bus_req_t    req_i,
    output uart_pkg::uart_bus_rsp_t         rsp_o,
    output uart_pkg::uart_cfg_t             cfg_o,
    output logic                            tx_start_o,
    output logic [`UART_DATA_SIZE-1:0]      tx_data_o,
    input  wire logic                       tx_ready_i,
    input  wire uart_pkg::uart_rx_byte_t    rx_byte_i
);

    import uart_pkg::*;

    logic                               wr_en;
    logic                               rd_en;
    logic                               tx_ready;
    logic                               data_accept;
    logic                               data_read;
    logic                               status_read;
    logic [`UART_BAUD_DIV_SIZE-1:0]     baud_div_ff;
    logic                               two_stop_ff;
    logic                               tx_start_ff;
    logic [`UART_DATA_SIZE-1:0]         tx_data_ff;
    logic [`UART_DATA_SIZE-1:0]         rx_buf_ff;
    logic                               rx_full_ff;
    logic                               frame_err_ff;
    logic                               overrun_ff;
    logic [`UART_REG_SIZE-1:0]          rdata_next;
    logic [`UART_REG_SIZE-1:0]          rdata_ff;
    logic                               rvalid_ff;

    assign wr_en = (req_i.op == REG_WRITE);
    assign rd_en = (req_i.op == REG_READ);

    // the transmitter still reports ready in the cycle of a pending start
    assign tx_ready    = tx_ready_i && !tx_start_ff;
    assign data_accept = wr_en && (req_i.addr == `UART_ADDR_DATA) && tx_ready;
    assign data_read   = rd_en && (req_i.addr == `UART_ADDR_DATA);
    assign status_read = rd_en && (req_i.addr == `UART_ADDR_STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_div_ff <= `UART_BAUD_DIV_RESET;
            two_stop_ff <= 1'b0;
        end else if (wr_en) begin
            if (req_i.addr == `UART_ADDR_CTRL) begin
                baud_div_ff <= req_i.wdata[`UART_BAUD_DIV_SIZE-1:0];
            end
            if (req_i.addr == `UART_ADDR_STOP) begin
                two_stop_ff <= req_i.wdata[0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_start_ff <= 1'b0;
        end else begin
            tx_start_ff <= data_accept;
        end
    end

    // tx_data stays put until the next accepted write, the transmitter loads it in TX_START
    always_ff @(posedge clk) begin
        if (data_accept) begin
            tx_data_ff <= req_i.wdata[`UART_DATA_SIZE-1:0];
        end
        if (rx_byte_i.valid) begin
            rx_buf_ff <= rx_byte_i.data;
        end
    end

    // a new byte wins over a clearing read in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_full_ff   <= 1'b0;
            frame_err_ff <= 1'b0;
            overrun_ff   <= 1'b0;
        end else begin
            if (rx_byte_i.valid) begin
                rx_full_ff <= 1'b1;
            end else if (data_read) begin
                rx_full_ff <= 1'b0;
            end

            if (rx_byte_i.valid && rx_byte_i.frame_err) begin
                frame_err_ff <= 1'b1;
            end else if (status_read) begin
                frame_err_ff <= 1'b0;
            end

            if (rx_byte_i.valid && rx_full_ff && !data_read) begin
                overrun_ff <= 1'b1;
            end else if (status_read) begin
                overrun_ff <= 1'b0;
            end
        end
    end

    always_comb begin
        case (req_i.addr)
            `UART_ADDR_DATA:   rdata_next = `UART_REG_SIZE'(rx_buf_ff);
            `UART_ADDR_CTRL:   rdata_next = `UART_REG_SIZE'(baud_div_ff);
            `UART_ADDR_STATUS: begin
                rdata_next = `UART_REG_SIZE'({overrun_ff, frame_err_ff, rx_full_ff, tx_ready});
            end
            `UART_ADDR_STOP:   rdata_next = `UART_REG_SIZE'(two_stop_ff);
            default:           rdata_next = '0;
        endcase
    end

    // read data shows up one clock after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_ff <= 1'b0;
        end else begin
            rvalid_ff <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_ff <= rdata_next;
        end
    end

    assign rsp_o      = '{rvalid: rvalid_ff, rdata: rdata_ff};
    assign cfg_o      = '{baud_div: baud_div_ff, two_stop: two_stop_ff};
    assign tx_start_o = tx_start_ff;
    assign tx_data_o  = tx_data_ff;

endmodule

`default_nettype wire

// ==== logic/uart_core.sv ====
// uart core top level joining the register block to the transmitter and the receiver

`default_nettype none

`include "uart_macros.svh"

module uart_core (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire uart_pkg::uart_bus_req_t    req_i,
    output uart_pkg::uart_bus_rsp_t         rsp_o,
    input  wire logic                       rx_i,
    output logic                            tx_o
);

    import uart_pkg::*;

    uart_cfg_t                      cfg;
    logic                           tx_start;
    logic [`UART_DATA_SIZE-1:0]     tx_data;
    logic                           tx_ready;
    uart_rx_byte_t                  rx_byte;

    uart_regs i_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .rsp_o      (rsp_o),
        .cfg_o      (cfg),
        .tx_start_o (tx_start),
        .tx_data_o  (tx_data),
        .tx_ready_i (tx_ready),
        .rx_byte_i  (rx_byte)
    );

    uart_tx i_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_i   (cfg),
        .start_i (tx_start),
        .data_i  (tx_data),
        .ready_o (tx_ready),
        .tx_o    (tx_o)
    );

    // the receiver uses the same divider as the transmitter
    uart_rx i_rx (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg_i  (cfg),
        .rx_i   (rx_i),
        .byte_o (rx_byte)
    );

endmodule

`default_nettype wire

// ==== sim/uart_core_tb.sv ====
// uart core testbench with loopback, injected bad frames and checks on the register port and pin

`default_nettype none

`include "uart_macros.svh"

module uart_core_tb;

    import uart_pkg::*;

    localparam int RVALID_LIMIT = 8;
    localparam int POLL_LIMIT   = 200;

    logic          clk;
    logic          rst_n;
    uart_bus_req_t req;
    uart_bus_rsp_t rsp;
    logic          tx_line;
    logic          rx_line;
    logic          inject_en;
    logic          inject_bit;

    integer        seed;
    int            check_errors;
    int            pin_errors;
    int            protocol_errors;
    int            timeout_count;
    int            cur_div;
    logic          cur_two_stop;

    // frame monitor state
    logic          in_frame;
    int            frame_len;
    int            low_run;
    int            expected_len;

    int            divs[2] = '{4, 7};
    logic [15:0]   status;
    logic [15:0]   rdata;
    logic [31:0]   rand_word;
    logic [7:0]    byte_a;
    logic [7:0]    byte_b;

    // tx loops back to rx unless a bad frame is being injected
    assign rx_line = inject_en ? inject_bit : tx_line;

    uart_core i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (req),
        .rsp_o (rsp),
        .rx_i  (rx_line),
        .tx_o  (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assert property (@(posedge clk) disable iff (!rst_n) (req.op == REG_READ) |=> rsp.rvalid)
        else begin
            protocol_errors++;
            $display("Error: time %0t rsp_o.rvalid expected 1 got %0b",
                     $time, $sampled(rsp.rvalid));
        end

    assert property (@(posedge clk) disable iff (!rst_n) (req.op != REG_READ) |=> !rsp.rvalid)
        else begin
            protocol_errors++;
            $display("Error: time %0t rsp_o.rvalid expected 0 got %0b",
                     $time, $sampled(rsp.rvalid));
        end

    // the line must rest high whenever the transmitter is idle
    assert property (@(posedge clk) disable iff (!rst_n) i_dut.tx_ready |-> tx_line)
        else begin
            protocol_errors++;
            $display("Error: time %0t tx_o expected 1 got %0b", $time, $sampled(tx_line));
        end

    // measures every frame on the pin from the start edge until tx_ready returns
    always @(negedge clk) begin
        if (!rst_n) begin
            in_frame  = 1'b0;
            frame_len = 0;
            low_run   = 0;
        end else if (in_frame) begin
            if (i_dut.tx_ready) begin
                expected_len = (cur_two_stop ? 11 : 10) * cur_div;
                assert (frame_len == expected_len) else begin
                    pin_errors++;
                    $display("Error: time %0t tx_o frame length expected %0d got %0d",
                             $time, expected_len, frame_len);
                end
                in_frame = 1'b0;
            end else begin
                frame_len++;
                if (!tx_line) begin
                    low_run++;
                end else if (low_run > 0) begin
                    assert (low_run % cur_div == 0) else begin
                        pin_errors++;
                        $display("Error: time %0t tx_o low for %0d clocks, not a multiple of %0d",
                                 $time, low_run, cur_div);
                    end
                    low_run = 0;
                end
            end
        end else if (!tx_line) begin
            in_frame  = 1'b1;
            frame_len = 1;
            low_run   = 1;
        end
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual == expected) else begin
            check_errors++;
            $display("Error: time %0t %s expected 0x%0h got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic write_reg(input logic [1:0] reg_addr, input logic [15:0] reg_data);
        @(posedge clk);
        req <= '{op: REG_WRITE, addr: reg_addr, wdata: reg_data};
        @(posedge clk);
        req <= '{op: REG_NONE, addr: 2'd0, wdata: 16'd0};
    endtask

    // two writes to the same address on consecutive clocks
    task automatic back_to_back_write(input logic [1:0] reg_addr, input logic [15:0] first_data,
                                      input logic [15:0] second_data);
        @(posedge clk);
        req <= '{op: REG_WRITE, addr: reg_addr, wdata: first_data};
        @(posedge clk);
        req <= '{op: REG_WRITE, addr: reg_addr, wdata: second_data};
        @(posedge clk);
        req <= '{op: REG_NONE, addr: 2'd0, wdata: 16'd0};
    endtask

    task automatic read_reg(input logic [1:0] reg_addr, output logic [15:0] reg_data);
        int waited;
        waited = 0;
        @(posedge clk);
        req <= '{op: REG_READ, addr: reg_addr, wdata: 16'd0};
        @(posedge clk);
        req <= '{op: REG_NONE, addr: 2'd0, wdata: 16'd0};
        @(negedge clk);
        while (!rsp.rvalid && waited < RVALID_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (rsp.rvalid) begin
            reg_data = rsp.rdata;
        end else begin
            timeout_count++;
            reg_data = 16'd0;
            $display("Timeout: no read response for address %0d", reg_addr);
        end
    endtask

    // polls STATUS until one of the bits in mask is set
    task automatic wait_status(input logic [15:0] mask, input string what,
                               output logic [15:0] value);
        int polls;
        polls = 0;
        read_reg(`UART_ADDR_STATUS, value);
        while ((value & mask) == 16'd0 && polls < POLL_LIMIT) begin
            polls++;
            read_reg(`UART_ADDR_STATUS, value);
        end
        if ((value & mask) == 16'd0) begin
            timeout_count++;
            $display("Timeout: %s never showed up in the status register", what);
        end
    endtask

    task automatic set_line(input int div, input logic two_stop);
        logic [15:0] value;
        wait_status(16'h0001, "tx_ready", value);
        write_reg(`UART_ADDR_CTRL, 16'(div));
        write_reg(`UART_ADDR_STOP, {15'd0, two_stop});
        cur_div      = div;
        cur_two_stop = two_stop;
    endtask

    task automatic loopback_byte();
        logic [15:0] value;
        logic [7:0]  tx_byte;
        wait_status(16'h0001, "tx_ready", value);
        rand_word = $random(seed);
        tx_byte   = rand_word[7:0];
        write_reg(`UART_ADDR_DATA, {8'h00, tx_byte});
        wait_status(16'h0002, "rx_full", value);
        read_reg(`UART_ADDR_DATA, value);
        check_value("rsp_o.rdata of DATA", {8'h00, tx_byte}, value);
        read_reg(`UART_ADDR_STATUS, value);
        check_value("rsp_o.rdata of STATUS bits 3:1", 16'h0000, value & 16'h000e);
    endtask

    // drives one frame straight onto rx, each bit held for one bit time
    task automatic send_raw_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge clk);
            inject_bit <= bits[b];
            repeat (cur_div - 1) @(posedge clk);
        end
        @(posedge clk);
        inject_bit <= 1'b1;
    endtask

    initial begin
        seed            = 37;
        check_errors    = 0;
        pin_errors      = 0;
        protocol_errors = 0;
        timeout_count   = 0;
        cur_div         = 16;
        cur_two_stop    = 1'b0;
        rst_n           = 1'b0;
        inject_en       = 1'b0;
        inject_bit      = 1'b1;
        req             = '{op: REG_NONE, addr: 2'd0, wdata: 16'd0};

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // reset values
        @(negedge clk);
        check_value("tx_o", 16'h0001, {15'd0, tx_line});
        check_value("rsp_o.rvalid", 16'h0000, {15'd0, rsp.rvalid});
        read_reg(`UART_ADDR_STATUS, status);
        check_value("rsp_o.rdata of STATUS after reset", 16'h0001, status);
        read_reg(`UART_ADDR_CTRL, rdata);
        check_value("rsp_o.rdata of CTRL after reset", 16'd16, rdata);

        // loopback across both dividers and both stop modes
        foreach (divs[i]) begin
            for (int stop = 0; stop < 2; stop++) begin
                set_line(divs[i], stop[0]);
                repeat (3) loopback_byte();
            end
        end

        // the second write follows the first at once, while its start is still pending
        wait_status(16'h0001, "tx_ready", status);
        rand_word = $random(seed);
        byte_a    = rand_word[7:0];
        byte_b    = ~byte_a;
        back_to_back_write(`UART_ADDR_DATA, {8'h00, byte_a}, {8'h00, byte_b});
        wait_status(16'h0002, "rx_full", status);
        read_reg(`UART_ADDR_DATA, rdata);
        check_value("rsp_o.rdata of DATA after dropped write", {8'h00, byte_a}, rdata);
        wait_status(16'h0001, "tx_ready", status);
        read_reg(`UART_ADDR_STATUS, status);
        check_value("rsp_o.rdata of STATUS after dropped write", 16'h0001, status);

        // two frames without a DATA read in between
        rand_word = $random(seed);
        byte_a    = rand_word[7:0];
        byte_b    = ~byte_a;
        write_reg(`UART_ADDR_DATA, {8'h00, byte_a});
        wait_status(16'h0002, "rx_full", status);
        wait_status(16'h0001, "tx_ready", status);
        write_reg(`UART_ADDR_DATA, {8'h00, byte_b});
        wait_status(16'h0008, "overrun", status);
        read_reg(`UART_ADDR_DATA, rdata);
        check_value("rsp_o.rdata of DATA after overrun", {8'h00, byte_b}, rdata);
        read_reg(`UART_ADDR_STATUS, status);
        check_value("rsp_o.rdata of STATUS bits 3:1", 16'h0000, status & 16'h000e);

        // a frame with a low stop bit
        wait_status(16'h0001, "tx_ready", status);
        rand_word = $random(seed);
        byte_a    = rand_word[7:0];
        @(posedge clk);
        inject_en <= 1'b1;
        send_raw_frame(byte_a, 1'b0);
        wait_status(16'h0004, "frame_err", status);
        check_value("rsp_o.rdata of STATUS rx_full bit", 16'h0002, status & 16'h0002);
        @(posedge clk);
        inject_en <= 1'b0;
        read_reg(`UART_ADDR_DATA, rdata);
        check_value("rsp_o.rdata of DATA for bad frame", {8'h00, byte_a}, rdata);
        read_reg(`UART_ADDR_STATUS, status);
        check_value("rsp_o.rdata of STATUS bits 3:1", 16'h0000, status & 16'h000e);

        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d pin timing, %0d protocol, %0d timeouts",
                 check_errors, pin_errors, protocol_errors, timeout_count);
        if (check_errors == 0 && pin_errors == 0 &&
            protocol_errors == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_core.f ====
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_core.sv
sim/uart_core_tb.sv

// ==== Makefile ====
SOURCES = uart_core.f logic/uart_macros.svh logic/uart_pkg.sv logic/uart_tx.sv \
          logic/uart_rx.sv logic/uart_regs.sv logic/uart_core.sv sim/uart_core_tb.sv

.PHONY: run clean

run: obj_dir/Vuart_core_tb
	@out="$$(./obj_dir/Vuart_core_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

obj_dir/Vuart_core_tb: $(SOURCES)
	verilator --binary --timing --assert -f uart_core.f --top-module uart_core_tb

clean:
	rm -rf obj_dir
